/* Makefile */
# Verilator build and run for the branch cache testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_cache
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hw/bpred_counter_array.sv */
// Branch cache prediction counters
// One 2-bit saturating state per entry, trained on a hit,
// started from weakly not taken on an allocate

`timescale 1ns/1ps

`include "bpred_macros.svh"

module bpred_counter_array (
	input  logic              iCLOCK,
	input  logic              inRESET,
	input  logic              clear,
	input  bpred_pkg::addr_t  search_addr,
	input  bpred_pkg::addr_t  update_addr,
	input  logic              search_hit,
	input  bpred_pkg::way_t   search_way,
	input  logic              wr_en,
	input  logic              alloc,
	input  logic              taken,
	input  bpred_pkg::way_t   wr_way,
	output logic              search_taken
);

	bpred_pkg::pred_state_t states [`BP_WAYS][`BP_SETS];

	bpred_pkg::index_t      s_idx;
	bpred_pkg::index_t      u_idx;
	bpred_pkg::pred_state_t s_state;
	bpred_pkg::pred_state_t base_state;

	assign s_idx = search_addr[`BP_OFFSET_W +: `BP_INDEX_W];
	assign u_idx = update_addr[`BP_OFFSET_W +: `BP_INDEX_W];

	function automatic bpred_pkg::pred_state_t next_state(bpred_pkg::pred_state_t cur,
		logic tk);
		case (cur)
			bpred_pkg::PRED_STRONG_NT: return tk ? bpred_pkg::PRED_WEAK_NT : bpred_pkg::PRED_STRONG_NT;
			bpred_pkg::PRED_WEAK_NT:   return tk ? bpred_pkg::PRED_WEAK_T : bpred_pkg::PRED_STRONG_NT;
			bpred_pkg::PRED_WEAK_T:    return tk ? bpred_pkg::PRED_STRONG_T : bpred_pkg::PRED_WEAK_NT;
			default:                   return tk ? bpred_pkg::PRED_STRONG_T : bpred_pkg::PRED_WEAK_T;
		endcase
	endfunction

	// Lookup
	assign s_state      = states[search_way][s_idx];
	assign search_taken = search_hit && ((s_state == bpred_pkg::PRED_WEAK_T) ||
		(s_state == bpred_pkg::PRED_STRONG_T));

	// New entries start weakly not taken before the outcome is applied
	assign base_state = alloc ? bpred_pkg::PRED_WEAK_NT : states[wr_way][u_idx];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < `BP_WAYS; w++) begin
				for (int s = 0; s < `BP_SETS; s++) begin
					states[w][s] <= bpred_pkg::PRED_WEAK_NT;
				end
			end
		end else if (clear) begin
			for (int w = 0; w < `BP_WAYS; w++) begin
				for (int s = 0; s < `BP_SETS; s++) begin
					states[w][s] <= bpred_pkg::PRED_WEAK_NT;
				end
			end
		end else if (wr_en) begin
			states[wr_way][u_idx] <= next_state(base_state, taken);
		end
	end

endmodule

/* hw/bpred_macros.svh */
// Branch predictor geometry
// Address split as tag | set index | byte offset,
// with a two-way set-associative branch cache

`ifndef BPRED_MACROS_SVH
`define BPRED_MACROS_SVH

// Instruction address width
`define BP_ADDR_W 32

// Byte offset below the set index
`define BP_OFFSET_W 2

// Set index bits and resulting set count
`define BP_INDEX_W 3
`define BP_SETS (1 << `BP_INDEX_W)

// Tag bits above the index
`define BP_TAG_W 27

// Associativity
`define BP_WAYS 2

`endif

/* hw/bpred_pkg.sv */
// Branch predictor types
// Address, tag, index, age and way vectors plus the
// 2-bit prediction state encoding

`include "bpred_macros.svh"

package bpred_pkg;

	typedef logic [`BP_ADDR_W-1:0]  addr_t;
	typedef logic [`BP_TAG_W-1:0]   tag_t;
	typedef logic [`BP_INDEX_W-1:0] index_t;

	// 0 invalid, 3 newest, valid entries age down to 1
	typedef logic [1:0] age_t;

	typedef logic way_t;

	// Taken prediction for WEAK_T and STRONG_T only
	typedef enum logic [1:0] {
		PRED_WEAK_NT   = 2'd0,
		PRED_WEAK_T    = 2'd1,
		PRED_STRONG_T  = 2'd2,
		PRED_STRONG_NT = 2'd3
	} pred_state_t;

endpackage

/* hw/bpred_tag_array.sv */
// Branch cache tag array
// Holds a tag and an age for every set and way, looks up the
// search and update addresses combinationally and ages the
// set on every write

`timescale 1ns/1ps

`include "bpred_macros.svh"

module bpred_tag_array (
	input  logic              iCLOCK,
	input  logic              inRESET,
	input  logic              clear,
	input  bpred_pkg::addr_t  search_addr,
	input  bpred_pkg::addr_t  update_addr,
	input  logic              wr_en,
	input  bpred_pkg::way_t   wr_way,
	input  bpred_pkg::age_t   other_age,
	output logic              search_hit,
	output bpred_pkg::way_t   search_way,
	output logic              upd_hit,
	output bpred_pkg::way_t   upd_way,
	output bpred_pkg::age_t   age0,
	output bpred_pkg::age_t   age1
);

	bpred_pkg::tag_t tags [`BP_WAYS][`BP_SETS];
	bpred_pkg::age_t ages [`BP_WAYS][`BP_SETS];

	bpred_pkg::index_t s_idx;
	bpred_pkg::index_t u_idx;
	bpred_pkg::tag_t   s_tag;
	bpred_pkg::tag_t   u_tag;

	assign s_idx = search_addr[`BP_OFFSET_W +: `BP_INDEX_W];
	assign u_idx = update_addr[`BP_OFFSET_W +: `BP_INDEX_W];
	assign s_tag = search_addr[`BP_ADDR_W-1 -: `BP_TAG_W];
	assign u_tag = update_addr[`BP_ADDR_W-1 -: `BP_TAG_W];

	// Returns {hit, way}, both ways are compared
	function automatic logic [1:0] lookup(bpred_pkg::index_t idx, bpred_pkg::tag_t tag);
		logic hit0;
		logic hit1;
		hit0 = (ages[0][idx] != 2'd0) && (tags[0][idx] == tag);
		hit1 = (ages[1][idx] != 2'd0) && (tags[1][idx] == tag);
		return {hit0 | hit1, hit1};
	endfunction

	assign {search_hit, search_way} = lookup(s_idx, s_tag);
	assign {upd_hit, upd_way}       = lookup(u_idx, u_tag);

	// Ages of the update set for victim choice
	assign age0 = ages[0][u_idx];
	assign age1 = ages[1][u_idx];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < `BP_WAYS; w++) begin
				for (int s = 0; s < `BP_SETS; s++) begin
					ages[w][s] <= 2'd0;
				end
			end
		end else if (clear) begin
			for (int w = 0; w < `BP_WAYS; w++) begin
				for (int s = 0; s < `BP_SETS; s++) begin
					ages[w][s] <= 2'd0;
				end
			end
		end else if (wr_en) begin
			ages[wr_way][u_idx]  <= 2'd3;
			ages[~wr_way][u_idx] <= other_age;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			tags[wr_way][u_idx] <= u_tag;
		end
	end

	// A set never ends up with one tag valid in both ways
	for (genvar s = 0; s < `BP_SETS; s++) begin : g_unique_tag
		a_unique_tag: assert property (@(posedge iCLOCK) disable iff (!inRESET)
			!((ages[0][s] != 2'd0) && (ages[1][s] != 2'd0) && (tags[0][s] == tags[1][s])));
	end

endmodule

/* hw/bpred_target_buffer.sv */
// Branch target buffer
// Stores one target per entry and returns it on a search hit,
// zero otherwise

`timescale 1ns/1ps

`include "bpred_macros.svh"

module bpred_target_buffer (
	input  logic              iCLOCK,
	input  bpred_pkg::addr_t  search_addr,
	input  bpred_pkg::addr_t  update_addr,
	input  bpred_pkg::addr_t  update_target,
	input  logic              search_hit,
	input  bpred_pkg::way_t   search_way,
	input  logic              wr_en,
	input  logic              alloc,
	input  logic              update_jump,
	input  bpred_pkg::way_t   wr_way,
	output bpred_pkg::addr_t  search_target
);

	bpred_pkg::addr_t targets [`BP_WAYS][`BP_SETS];

	bpred_pkg::index_t s_idx;
	bpred_pkg::index_t u_idx;

	assign s_idx = search_addr[`BP_OFFSET_W +: `BP_INDEX_W];
	assign u_idx = update_addr[`BP_OFFSET_W +: `BP_INDEX_W];

	assign search_target = search_hit ? targets[search_way][s_idx] : '0;

	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			if (update_jump) begin
				targets[wr_way][u_idx] <= update_target;
			end else if (alloc) begin
				// Fresh not-taken entry has no known target
				targets[wr_way][u_idx] <= '0;
			end
		end
	end

endmodule

/* hw/bpred_update_ctrl.sv */
// Branch cache update control
// Resolves the outcome of an update, picks train or allocate,
// chooses the victim way and ages the other way of the set

`timescale 1ns/1ps

module bpred_update_ctrl (
	input  logic             iCLOCK,
	input  logic             inRESET,
	input  logic             reset_sync,
	input  logic             flush,
	input  logic             update_stb,
	input  logic             update_predict,
	input  logic             update_hit,
	input  logic             update_jump,
	input  logic             upd_hit,
	input  bpred_pkg::way_t  upd_way,
	input  bpred_pkg::age_t  age0,
	input  bpred_pkg::age_t  age1,
	output logic             clear,
	output logic             wr_en,
	output logic             alloc,
	output logic             taken,
	output bpred_pkg::way_t  wr_way,
	output bpred_pkg::age_t  other_age
);

	bpred_pkg::way_t victim;
	bpred_pkg::age_t old_age;

	assign clear = reset_sync | flush;

	// Clear takes priority over any update
	assign wr_en = update_stb & ~clear;

	assign taken = update_jump | (update_predict & update_hit);
	assign alloc = ~upd_hit;

	// Invalid way first, else the older one, way 0 on a tie
	always_comb begin
		if (age0 == 2'd0) begin
			victim = 1'b0;
		end else if (age1 == 2'd0) begin
			victim = 1'b1;
		end else if (age0 <= age1) begin
			victim = 1'b0;
		end else begin
			victim = 1'b1;
		end
	end

	assign wr_way = upd_hit ? upd_way : victim;

	// Other way ages by one and stops at 1 while valid
	assign old_age   = wr_way ? age0 : age1;
	assign other_age = (old_age <= 2'd1) ? old_age : old_age - 2'd1;

	// Any set reads empty in the cycle after a clear
	a_no_write_on_clear: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		clear |=> (age0 == 2'd0) && (age1 == 2'd0));

	// A trained way is always a valid entry of the set
	a_train_hit_way: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(wr_en && upd_hit) |-> ((wr_way ? age1 : age0) != 2'd0));

endmodule

/* hw/branch_cache.sv */
// Branch cache top
// Two-way, eight-set branch predictor with target buffer.
// Search is combinational, updates and clears land at the clock edge

`timescale 1ns/1ps

module branch_cache (
	input  logic              iCLOCK,
	input  logic              inRESET,
	input  logic              reset_sync,
	input  logic              flush,
	input  logic              search_stb,
	input  bpred_pkg::addr_t  search_addr,
	output logic              search_valid,
	output logic              search_hit,
	output logic              search_taken,
	output bpred_pkg::addr_t  search_target,
	input  logic              update_stb,
	input  bpred_pkg::addr_t  update_addr,
	input  logic              update_predict,
	input  logic              update_hit,
	input  logic              update_jump,
	input  bpred_pkg::addr_t  update_target
);

	logic            clear;
	logic            wr_en;
	logic            alloc;
	logic            taken;
	logic            upd_hit;
	bpred_pkg::way_t wr_way;
	bpred_pkg::way_t upd_way;
	bpred_pkg::way_t search_way;
	bpred_pkg::age_t other_age;
	bpred_pkg::age_t age0;
	bpred_pkg::age_t age1;

	assign search_valid = search_stb;

	bpred_update_ctrl u_ctrl (
		.iCLOCK, .inRESET, .reset_sync, .flush,
		.update_stb, .update_predict, .update_hit, .update_jump,
		.upd_hit, .upd_way, .age0, .age1,
		.clear, .wr_en, .alloc, .taken, .wr_way, .other_age
	);

	bpred_tag_array u_tags (
		.iCLOCK, .inRESET, .clear, .search_addr, .update_addr,
		.wr_en, .wr_way, .other_age,
		.search_hit, .search_way, .upd_hit, .upd_way, .age0, .age1
	);

	bpred_counter_array u_counters (
		.iCLOCK, .inRESET, .clear, .search_addr, .update_addr,
		.search_hit, .search_way, .wr_en, .alloc, .taken, .wr_way,
		.search_taken
	);

	bpred_target_buffer u_targets (
		.iCLOCK, .search_addr, .update_addr, .update_target,
		.search_hit, .search_way, .wr_en, .alloc, .update_jump, .wr_way,
		.search_target
	);

endmodule

/* sources.f */
+incdir+hw
hw/bpred_pkg.sv
hw/bpred_tag_array.sv
hw/bpred_counter_array.sv
hw/bpred_target_buffer.sv
hw/bpred_update_ctrl.sv
hw/branch_cache.sv
test/tb_branch_cache.sv

/* test/tb_branch_cache.sv */
// Branch cache testbench
// Directed tests against a reference model of the two-way
// branch cache, followed by a seeded random run

`timescale 1ns/1ps

`include "bpred_macros.svh"

module tb_branch_cache;

	logic             iCLOCK;
	logic             inRESET;
	logic             reset_sync;
	logic             flush;
	logic             search_stb;
	bpred_pkg::addr_t search_addr;
	logic             search_valid;
	logic             search_hit;
	logic             search_taken;
	bpred_pkg::addr_t search_target;
	logic             update_stb;
	bpred_pkg::addr_t update_addr;
	logic             update_predict;
	logic             update_hit;
	logic             update_jump;
	bpred_pkg::addr_t update_target;

	// Reference model of the cache contents
	bpred_pkg::tag_t        m_tag   [`BP_WAYS][`BP_SETS];
	bpred_pkg::age_t        m_age   [`BP_WAYS][`BP_SETS];
	bpred_pkg::pred_state_t m_state [`BP_WAYS][`BP_SETS];
	bpred_pkg::addr_t       m_tgt   [`BP_WAYS][`BP_SETS];

	int    errors;
	int    checks;
	int    start_errors;
	string test_name;

	branch_cache UUT (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #10 iCLOCK = ~iCLOCK;
	end

	function automatic bpred_pkg::addr_t make_addr(bpred_pkg::tag_t tag, bpred_pkg::index_t idx);
		return {tag, idx, {`BP_OFFSET_W{1'b0}}};
	endfunction

	// Strength level 0..3 from strongly not taken to strongly taken
	function automatic bpred_pkg::pred_state_t next_pred(bpred_pkg::pred_state_t s, logic tk);
		int lvl;
		case (s)
			bpred_pkg::PRED_STRONG_NT: lvl = 0;
			bpred_pkg::PRED_WEAK_NT:   lvl = 1;
			bpred_pkg::PRED_WEAK_T:    lvl = 2;
			default:                   lvl = 3;
		endcase
		if (tk && lvl < 3) lvl++;
		else if (!tk && lvl > 0) lvl--;
		case (lvl)
			0:       return bpred_pkg::PRED_STRONG_NT;
			1:       return bpred_pkg::PRED_WEAK_NT;
			2:       return bpred_pkg::PRED_WEAK_T;
			default: return bpred_pkg::PRED_STRONG_T;
		endcase
	endfunction

	task automatic clear_model();
		for (int w = 0; w < `BP_WAYS; w++) begin
			for (int s = 0; s < `BP_SETS; s++) begin
				m_age[w][s] = 2'd0;
				m_state[w][s] = bpred_pkg::PRED_WEAK_NT;
			end
		end
	endtask

	task automatic model_lookup(input bpred_pkg::addr_t addr, output logic hit,
		output bpred_pkg::way_t way);
		bpred_pkg::index_t idx;
		bpred_pkg::tag_t   tag;
		idx = addr[`BP_OFFSET_W +: `BP_INDEX_W];
		tag = addr[`BP_ADDR_W-1 -: `BP_TAG_W];
		hit = 1'b0;
		way = 1'b0;
		for (int w = 0; w < `BP_WAYS; w++) begin
			if (m_age[w][idx] != 2'd0 && m_tag[w][idx] == tag) begin
				hit = 1'b1;
				way = (w == 1);
			end
		end
	endtask

	// What the next clock edge does to the model
	task automatic apply_model_edge();
		logic              hit;
		logic              tk;
		bpred_pkg::way_t   w;
		bpred_pkg::age_t   oa;
		bpred_pkg::index_t idx;
		if (reset_sync || flush) begin
			clear_model();
		end else if (update_stb) begin
			idx = update_addr[`BP_OFFSET_W +: `BP_INDEX_W];
			model_lookup(update_addr, hit, w);
			tk = update_jump | (update_predict & update_hit);
			if (!hit) begin
				if (m_age[0][idx] == 2'd0) w = 1'b0;
				else if (m_age[1][idx] == 2'd0) w = 1'b1;
				else w = (m_age[1][idx] < m_age[0][idx]);
			end
			oa = m_age[~w][idx];
			if (oa > 2'd1) oa = oa - 2'd1;
			m_age[~w][idx] = oa;
			m_age[w][idx] = 2'd3;
			m_tag[w][idx] = update_addr[`BP_ADDR_W-1 -: `BP_TAG_W];
			m_state[w][idx] = next_pred(hit ? m_state[w][idx] : bpred_pkg::PRED_WEAK_NT, tk);
			if (update_jump) m_tgt[w][idx] = update_target;
			else if (!hit) m_tgt[w][idx] = '0;
		end
	endtask

	task automatic check_bit(string what, logic exp, logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_addr(string what, bpred_pkg::addr_t exp, bpred_pkg::addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic drive_update(bpred_pkg::addr_t addr, logic predict, logic hit, logic jump,
		bpred_pkg::addr_t target);
		update_stb = 1'b1;
		update_addr = addr;
		update_predict = predict;
		update_hit = hit;
		update_jump = jump;
		update_target = target;
	endtask

	// Search in the current cycle, compared with the model before the edge
	task automatic search_and_compare(bpred_pkg::addr_t addr);
		logic              hit;
		bpred_pkg::way_t   w;
		bpred_pkg::index_t idx;
		bpred_pkg::pred_state_t st;
		int                n;
		search_stb = 1'b1;
		search_addr = addr;
		n = 0;
		do begin
			#1;
			n++;
		end while (search_valid !== 1'b1 && n < 4);
		if (search_valid !== 1'b1) begin
			errors++;
			$display("[%s] search_valid did not follow search_stb within %0d ns", test_name, n);
		end
		idx = addr[`BP_OFFSET_W +: `BP_INDEX_W];
		model_lookup(addr, hit, w);
		st = m_state[w][idx];
		check_bit("search_hit", hit, search_hit);
		check_bit("search_taken", hit && (st == bpred_pkg::PRED_WEAK_T ||
			st == bpred_pkg::PRED_STRONG_T), search_taken);
		check_addr("search_target", hit ? m_tgt[w][idx] : '0, search_target);
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic finish_cycle();
		apply_model_edge();
		@(posedge iCLOCK);
		#1;
		update_stb = 1'b0;
		search_stb = 1'b0;
		reset_sync = 1'b0;
		flush = 1'b0;
	endtask

	task automatic begin_test(string name);
		test_name = name;
		start_errors = errors;
	endtask

	task automatic end_test();
		$display("%-18s %s, %0d errors", test_name, (errors == start_errors) ? "ok" : "failed",
			errors - start_errors);
	endtask

	task automatic after_reset_misses();
		begin_test("after_reset");
		#1;
		check_bit("search_valid", 1'b0, search_valid);
		for (int i = 0; i < `BP_SETS; i++) begin
			search_and_compare(make_addr(27'h40 + i, i[2:0]));
			finish_cycle();
		end
		end_test();
	endtask

	task automatic taken_update_hits();
		begin_test("taken_update");
		drive_update(make_addr(27'h12, 3'd1), 1'b0, 1'b0, 1'b1, 32'h0000_8a40);
		finish_cycle();
		search_and_compare(make_addr(27'h12, 3'd1));
		drive_update(make_addr(27'h13, 3'd2), 1'b0, 1'b0, 1'b0, 32'h0000_9b00);
		finish_cycle();
		search_and_compare(make_addr(27'h13, 3'd2));
		finish_cycle();
		end_test();
	endtask

	task automatic counter_training();
		logic [11:0] outcomes;
		begin_test("counter_training");
		outcomes = 12'b0011_0000_1111;
		for (int i = 0; i < 12; i++) begin
			drive_update(make_addr(27'h21, 3'd4), 1'b0, 1'b1, outcomes[i], 32'h2000 + 4 * i);
			search_and_compare(make_addr(27'h21, 3'd4));
			finish_cycle();
			search_and_compare(make_addr(27'h21, 3'd4));
			finish_cycle();
		end
		end_test();
	endtask

	task automatic way_replacement();
		begin_test("replacement");
		drive_update(make_addr(27'h31, 3'd5), 1'b0, 1'b0, 1'b1, 32'h3100);
		finish_cycle();
		drive_update(make_addr(27'h32, 3'd5), 1'b0, 1'b0, 1'b1, 32'h3200);
		finish_cycle();
		search_and_compare(make_addr(27'h31, 3'd5));
		finish_cycle();
		search_and_compare(make_addr(27'h32, 3'd5));
		finish_cycle();
		// Third tag evicts the older first entry
		drive_update(make_addr(27'h33, 3'd5), 1'b0, 1'b0, 1'b1, 32'h3300);
		finish_cycle();
		for (int t = 0; t < 3; t++) begin
			search_and_compare(make_addr(27'h31 + t, 3'd5));
			finish_cycle();
		end
		end_test();
	endtask

	task automatic fill_and_clear(logic use_flush, logic with_update);
		for (int i = 0; i < 3; i++) begin
			drive_update(make_addr(27'h50 + i, i[2:0]), 1'b0, 1'b0, 1'b1, 32'h5000 + i);
			finish_cycle();
		end
		if (with_update) drive_update(make_addr(27'h57, 3'd6), 1'b0, 1'b0, 1'b1, 32'h5700);
		flush = use_flush;
		reset_sync = ~use_flush;
		finish_cycle();
		for (int i = 0; i < 3; i++) begin
			search_and_compare(make_addr(27'h50 + i, i[2:0]));
			finish_cycle();
		end
		search_and_compare(make_addr(27'h57, 3'd6));
		finish_cycle();
	endtask

	task automatic clear_empties_cache();
		begin_test("clear");
		fill_and_clear(1'b1, 1'b0);
		fill_and_clear(1'b0, 1'b0);
		fill_and_clear(1'b1, 1'b1);
		end_test();
	endtask

	task automatic random_traffic();
		logic [31:0] r;
		begin_test("random");
		for (int i = 0; i < 300; i++) begin
			r = $urandom;
			flush = (r[5:0] == 6'd0);
			if (r[6]) begin
				drive_update(make_addr(27'h60 + r[11:10], {1'b0, r[13:12]}),
					r[7], r[8], r[9], $urandom);
			end
			search_and_compare(make_addr(27'h60 + r[15:14], {1'b0, r[17:16]}));
			finish_cycle();
		end
		end_test();
	endtask

	initial begin
		errors = 0;
		checks = 0;
		inRESET = 1'b0;
		reset_sync = 1'b0;
		flush = 1'b0;
		search_stb = 1'b0;
		search_addr = '0;
		update_stb = 1'b0;
		update_addr = '0;
		update_predict = 1'b0;
		update_hit = 1'b0;
		update_jump = 1'b0;
		update_target = '0;
		void'($urandom(32'h88f4a08a));
		clear_model();
		repeat (16) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		after_reset_misses();
		taken_update_hits();
		counter_training();
		way_replacement();
		clear_empties_cache();
		random_traffic();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
